/* core_macros.svh */
// Core width and instruction field macros
// Shared by the ISA and pipeline packages and by the decode logic
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define DATA_W 32
`define REG_W 5
`define IMM_W 16

// Opcode field position
`define OPC_W 6
`define OPC_LSB 26

// Register field positions
`define DEST_LSB 21
`define SRC0_LSB 16
`define SRC1_LSB 11

// Condition code, low bits of the word
`define CC_W 4
`define CC_LSB 0

// Extra shift or advance data
`define ADV_W 6
`define ADV_LSB 5

`endif

/* isa_pkg.sv */
// Instruction set definitions
// Opcode encodings, execution unit one-hot select and per-unit command codes
`default_nettype none

`include "core_macros.svh"

package isa_pkg;

	typedef enum logic [`OPC_W-1:0] {
		// Register forms
		OP_ADD  = 6'h00,
		OP_SUB  = 6'h01,
		OP_AND  = 6'h02,
		OP_OR   = 6'h03,
		OP_XOR  = 6'h04,
		OP_SHL  = 6'h05,
		OP_SHR  = 6'h06,
		OP_MUL  = 6'h07,
		OP_UDIV = 6'h08,
		OP_SDIV = 6'h09,
		// Immediate forms
		OP_ADDI = 6'h10,
		OP_ANDI = 6'h12,
		OP_SHLI = 6'h15,
		// Memory and branch
		OP_LD   = 6'h18,
		OP_ST   = 6'h19,
		OP_BR   = 6'h20,
		// System register access
		OP_SRR  = 6'h28,
		OP_SRW  = 6'h29
	} opcode_t;

	typedef enum logic [9:0] {
		EX_NONE     = 10'b00_0000_0000,
		EX_SYS_REG  = 10'b10_0000_0000,
		EX_SYS_LDST = 10'b01_0000_0000,
		EX_LOGIC    = 10'b00_1000_0000,
		EX_SHIFT    = 10'b00_0100_0000,
		EX_ADDER    = 10'b00_0010_0000,
		EX_MUL      = 10'b00_0001_0000,
		EX_SDIV     = 10'b00_0000_1000,
		EX_UDIV     = 10'b00_0000_0100,
		EX_LDST     = 10'b00_0000_0010,
		EX_BRANCH   = 10'b00_0000_0001
	} ex_unit_t;

	typedef logic [4:0] cmd_t;

	// Command codes, meaningful only together with the unit select
	localparam cmd_t CMD_ADD = 5'd0;
	localparam cmd_t CMD_SUB = 5'd1;
	localparam cmd_t CMD_AND = 5'd0;
	localparam cmd_t CMD_OR  = 5'd1;
	localparam cmd_t CMD_XOR = 5'd2;
	localparam cmd_t CMD_SHL = 5'd0;
	localparam cmd_t CMD_SHR = 5'd1;
	localparam cmd_t CMD_LD  = 5'd0;
	localparam cmd_t CMD_ST  = 5'd1;
	localparam cmd_t CMD_BR  = 5'd0;
	localparam cmd_t CMD_SRR = 5'd0;
	localparam cmd_t CMD_SRW = 5'd1;
	localparam cmd_t CMD_MULDIV = 5'd0;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
// Pipeline bundles
// Fetch output, decoder control and operand results, and the decoded bundle
// that leaves the decode stage
`default_nettype none

`include "core_macros.svh"

package pipe_pkg;

	typedef struct packed {
		logic [`DATA_W-1:0] inst;
		logic [`DATA_W-1:0] pc;
		logic branch_predict;
		logic [`DATA_W-1:0] branch_predict_addr;
		logic pagefault;
		logic privilege_error;
		logic invalid_inst;
		logic paging_ena;
		logic kernel_access;
	} fetch_bundle_t;

	typedef struct packed {
		isa_pkg::cmd_t cmd;
		isa_pkg::ex_unit_t ex_unit;
		logic writeback;
		logic flags_writeback;
		logic source0_active;
		logic source1_active;
		logic source0_sysreg;
		logic destination_sysreg;
		logic source1_imm;
		logic commit_wait;
		logic error;
	} ctrl_bundle_t;

	typedef struct packed {
		logic [`REG_W-1:0] source0;
		logic [`REG_W-1:0] destination;
		logic [`DATA_W-1:0] source1;
		logic [`CC_W-1:0] cc;
		logic [`ADV_W-1:0] adv_data;
	} operand_bundle_t;

	// Fetch fields minus the raw word, plus both decoder results
	typedef struct packed {
		logic [`DATA_W-1:0] pc;
		logic branch_predict;
		logic [`DATA_W-1:0] branch_predict_addr;
		logic pagefault;
		logic privilege_error;
		logic invalid_inst;
		logic paging_ena;
		logic kernel_access;
		ctrl_bundle_t ctrl;
		operand_bundle_t operand;
	} decode_bundle_t;

endpackage

`default_nettype wire

/* decode_function.sv */
// Opcode decoder
// Maps the opcode field to command, unit select, writeback and source control
// Unknown opcodes raise error with no unit selected
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module decode_function (
	input wire [`DATA_W-1:0] inst,
	output pipe_pkg::ctrl_bundle_t ctrl
);

	isa_pkg::opcode_t opcode;
	logic reg_form;

	assign opcode = isa_pkg::opcode_t'(inst[`OPC_LSB +: `OPC_W]);
	// Register forms occupy the lowest opcode block
	assign reg_form = (inst[`OPC_LSB + `OPC_W - 1 -: 2] == 2'b00);

	always_comb begin
		ctrl.cmd = '0;
		ctrl.ex_unit = isa_pkg::EX_NONE;
		ctrl.writeback = 1'b1;
		ctrl.source0_active = 1'b1;
		ctrl.source1_active = reg_form;
		ctrl.source0_sysreg = 1'b0;
		ctrl.destination_sysreg = 1'b0;
		ctrl.source1_imm = 1'b0;
		ctrl.commit_wait = 1'b0;
		ctrl.error = 1'b0;
		case (opcode)
			isa_pkg::OP_ADD: begin
				ctrl.ex_unit = isa_pkg::EX_ADDER;
				ctrl.cmd = isa_pkg::CMD_ADD;
			end
			isa_pkg::OP_SUB: begin
				ctrl.ex_unit = isa_pkg::EX_ADDER;
				ctrl.cmd = isa_pkg::CMD_SUB;
			end
			isa_pkg::OP_AND: begin
				ctrl.ex_unit = isa_pkg::EX_LOGIC;
				ctrl.cmd = isa_pkg::CMD_AND;
			end
			isa_pkg::OP_OR: begin
				ctrl.ex_unit = isa_pkg::EX_LOGIC;
				ctrl.cmd = isa_pkg::CMD_OR;
			end
			isa_pkg::OP_XOR: begin
				ctrl.ex_unit = isa_pkg::EX_LOGIC;
				ctrl.cmd = isa_pkg::CMD_XOR;
			end
			isa_pkg::OP_SHL: begin
				ctrl.ex_unit = isa_pkg::EX_SHIFT;
				ctrl.cmd = isa_pkg::CMD_SHL;
			end
			isa_pkg::OP_SHR: begin
				ctrl.ex_unit = isa_pkg::EX_SHIFT;
				ctrl.cmd = isa_pkg::CMD_SHR;
			end
			isa_pkg::OP_MUL: begin
				ctrl.ex_unit = isa_pkg::EX_MUL;
				ctrl.cmd = isa_pkg::CMD_MULDIV;
			end
			// Divides are multi-cycle and hold commit
			isa_pkg::OP_UDIV: begin
				ctrl.ex_unit = isa_pkg::EX_UDIV;
				ctrl.cmd = isa_pkg::CMD_MULDIV;
				ctrl.commit_wait = 1'b1;
			end
			isa_pkg::OP_SDIV: begin
				ctrl.ex_unit = isa_pkg::EX_SDIV;
				ctrl.cmd = isa_pkg::CMD_MULDIV;
				ctrl.commit_wait = 1'b1;
			end
			isa_pkg::OP_ADDI: begin
				ctrl.ex_unit = isa_pkg::EX_ADDER;
				ctrl.cmd = isa_pkg::CMD_ADD;
				ctrl.source1_imm = 1'b1;
			end
			isa_pkg::OP_ANDI: begin
				ctrl.ex_unit = isa_pkg::EX_LOGIC;
				ctrl.cmd = isa_pkg::CMD_AND;
				ctrl.source1_imm = 1'b1;
			end
			isa_pkg::OP_SHLI: begin
				ctrl.ex_unit = isa_pkg::EX_SHIFT;
				ctrl.cmd = isa_pkg::CMD_SHL;
				ctrl.source1_imm = 1'b1;
			end
			isa_pkg::OP_LD: begin
				ctrl.ex_unit = isa_pkg::EX_LDST;
				ctrl.cmd = isa_pkg::CMD_LD;
				ctrl.source1_imm = 1'b1;
			end
			// Store reads the data register and the offset
			isa_pkg::OP_ST: begin
				ctrl.ex_unit = isa_pkg::EX_LDST;
				ctrl.cmd = isa_pkg::CMD_ST;
				ctrl.source1_imm = 1'b1;
				ctrl.source1_active = 1'b1;
				ctrl.writeback = 1'b0;
			end
			isa_pkg::OP_BR: begin
				ctrl.ex_unit = isa_pkg::EX_BRANCH;
				ctrl.cmd = isa_pkg::CMD_BR;
				ctrl.source0_active = 1'b0;
				ctrl.writeback = 1'b0;
			end
			isa_pkg::OP_SRR: begin
				ctrl.ex_unit = isa_pkg::EX_SYS_REG;
				ctrl.cmd = isa_pkg::CMD_SRR;
				ctrl.source0_active = 1'b0;
				ctrl.source0_sysreg = 1'b1;
			end
			isa_pkg::OP_SRW: begin
				ctrl.ex_unit = isa_pkg::EX_SYS_REG;
				ctrl.cmd = isa_pkg::CMD_SRW;
				ctrl.destination_sysreg = 1'b1;
				ctrl.commit_wait = 1'b1;
				ctrl.writeback = 1'b0;
			end
			default: begin
				ctrl.error = 1'b1;
				ctrl.writeback = 1'b0;
				ctrl.source0_active = 1'b0;
				ctrl.source1_active = 1'b0;
			end
		endcase
		// Only arithmetic and logic results update flags
		ctrl.flags_writeback = (ctrl.ex_unit == isa_pkg::EX_ADDER)
			|| (ctrl.ex_unit == isa_pkg::EX_LOGIC);
	end

	// At most one unit, and none only for an unknown opcode
	a_unit_select: assert final ($onehot0(ctrl.ex_unit)
		&& ((ctrl.ex_unit == isa_pkg::EX_NONE) == ctrl.error))
		else $error("decode_function: unit select %b with error %b",
			ctrl.ex_unit, ctrl.error);

endmodule

`default_nettype wire

/* operand_extract.sv */
// Operand field extraction
// Slices register numbers, condition code and shift data from the word
// and builds source1 from either the immediate or the register index
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module operand_extract (
	input wire [`DATA_W-1:0] inst,
	input wire source1_imm,
	output pipe_pkg::operand_bundle_t operand
);

	logic [`IMM_W-1:0] imm;
	logic [`REG_W-1:0] source1_idx;
	logic [`DATA_W-1:0] imm_sext;
	logic [`DATA_W-1:0] idx_zext;

	assign imm = inst[`IMM_W-1:0];
	assign source1_idx = inst[`SRC1_LSB +: `REG_W];

	// Immediate is signed
	assign imm_sext = {{(`DATA_W - `IMM_W){imm[`IMM_W-1]}}, imm};
	assign idx_zext = {{(`DATA_W - `REG_W){1'b0}}, source1_idx};

	assign operand.source0 = inst[`SRC0_LSB +: `REG_W];
	assign operand.destination = inst[`DEST_LSB +: `REG_W];
	assign operand.source1 = source1_imm ? imm_sext : idx_zext;

	// Both overlap the immediate field
	assign operand.cc = inst[`CC_LSB +: `CC_W];
	assign operand.adv_data = inst[`ADV_LSB +: `ADV_W];

endmodule

`default_nettype wire

/* decode_stage.sv */
// Decode stage
// Runs the opcode decoder and the operand extractor side by side,
// merges the invalid opcode fault and registers the decoded bundle
// under the valid/lock handshake with flush
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input wire iCLOCK,
	input wire inRESET,
	input wire reset_sync,
	input wire flush,
	input wire prev_valid,
	input wire pipe_pkg::fetch_bundle_t prev_fetch,
	output logic prev_lock,
	output logic next_valid,
	output pipe_pkg::decode_bundle_t next_decode,
	input wire next_lock
);

	pipe_pkg::ctrl_bundle_t ctrl;
	pipe_pkg::operand_bundle_t operand;
	pipe_pkg::decode_bundle_t decode_d;
	pipe_pkg::decode_bundle_t b_decode;
	logic b_valid;

	decode_function i_decode_function (
		.inst (prev_fetch.inst),
		.ctrl (ctrl)
	);

	operand_extract i_operand_extract (
		.inst (prev_fetch.inst),
		.source1_imm (ctrl.source1_imm),
		.operand (operand)
	);

	always_comb begin
		decode_d.pc = prev_fetch.pc;
		decode_d.branch_predict = prev_fetch.branch_predict;
		decode_d.branch_predict_addr = prev_fetch.branch_predict_addr;
		decode_d.pagefault = prev_fetch.pagefault;
		decode_d.privilege_error = prev_fetch.privilege_error;
		// Unknown opcode adds to any fault from fetch
		decode_d.invalid_inst = prev_fetch.invalid_inst | ctrl.error;
		decode_d.paging_ena = prev_fetch.paging_ena;
		decode_d.kernel_access = prev_fetch.kernel_access;
		decode_d.ctrl = ctrl;
		decode_d.operand = operand;
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= 1'b0;
			b_decode <= '0;
		end else if (reset_sync || flush) begin
			b_valid <= 1'b0;
			b_decode <= '0;
		end else if (!next_lock) begin
			b_valid <= prev_valid;
			b_decode <= decode_d;
		end
	end

	// Single entry, so back-pressure goes straight through
	assign prev_lock = next_lock;

	assign next_valid = b_valid;
	assign next_decode = b_decode;

	// Held output must not change while the next stage is locked
	a_lock_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(next_lock && !flush && !reset_sync) |=> ($stable(next_valid) && $stable(next_decode)))
		else $error("decode_stage: output changed under lock");

	// A flush always empties the stage on the following edge
	a_flush_empty: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(flush || reset_sync) |=> !next_valid)
		else $error("decode_stage: next_valid set after flush");

endmodule

`default_nettype wire

/* tb_decoder_tests.svh */
// Directed tests for the decode stage
// Expected bundles follow the ISA rules for each opcode

// Random word with the given opcode, random PC and prediction, no faults
function automatic pipe_pkg::fetch_bundle_t random_fetch(input logic [5:0] opc);
	pipe_pkg::fetch_bundle_t f;
	f = '0;
	f.inst = lcg_next();
	f.inst[31:26] = opc;
	f.pc = lcg_next();
	f.pc[1:0] = 2'b00;
	f.branch_predict_addr = lcg_next();
	f.branch_predict = lcg_state[16];
	f.paging_ena = lcg_state[17];
	f.kernel_access = lcg_state[18];
	return f;
endfunction

function automatic pipe_pkg::decode_bundle_t expected_decode(input pipe_pkg::fetch_bundle_t f);
	pipe_pkg::decode_bundle_t d;
	logic [5:0] opc;
	logic valid;
	d = '0;
	opc = f.inst[31:26];
	valid = 1'b1;
	case (opc)
		6'h00, 6'h01, 6'h10: d.ctrl.ex_unit = isa_pkg::EX_ADDER;
		6'h02, 6'h03, 6'h04, 6'h12: d.ctrl.ex_unit = isa_pkg::EX_LOGIC;
		6'h05, 6'h06, 6'h15: d.ctrl.ex_unit = isa_pkg::EX_SHIFT;
		6'h07: d.ctrl.ex_unit = isa_pkg::EX_MUL;
		6'h08: d.ctrl.ex_unit = isa_pkg::EX_UDIV;
		6'h09: d.ctrl.ex_unit = isa_pkg::EX_SDIV;
		6'h18, 6'h19: d.ctrl.ex_unit = isa_pkg::EX_LDST;
		6'h20: d.ctrl.ex_unit = isa_pkg::EX_BRANCH;
		6'h28, 6'h29: d.ctrl.ex_unit = isa_pkg::EX_SYS_REG;
		default: valid = 1'b0;
	endcase
	// SUB, OR, SHR, ST and SRW are command 1, XOR is 2
	if (opc inside {6'h01, 6'h03, 6'h06, 6'h19, 6'h29}) begin
		d.ctrl.cmd = 5'd1;
	end else if (opc == 6'h04) begin
		d.ctrl.cmd = 5'd2;
	end
	d.ctrl.error = !valid;
	d.ctrl.writeback = valid && !(opc inside {6'h19, 6'h20, 6'h29});
	d.ctrl.flags_writeback = d.ctrl.ex_unit inside {isa_pkg::EX_ADDER, isa_pkg::EX_LOGIC};
	d.ctrl.commit_wait = opc inside {6'h08, 6'h09, 6'h29};
	d.ctrl.source0_active = valid && !(opc inside {6'h20, 6'h28});
	d.ctrl.source1_active = valid && (opc <= 6'h09 || opc == 6'h19);
	d.ctrl.source1_imm = opc inside {6'h10, 6'h12, 6'h15, 6'h18, 6'h19};
	d.ctrl.source0_sysreg = (opc == 6'h28);
	d.ctrl.destination_sysreg = (opc == 6'h29);
	d.operand.source0 = f.inst[20:16];
	d.operand.destination = f.inst[25:21];
	d.operand.source1 = d.ctrl.source1_imm ? {{16{f.inst[15]}}, f.inst[15:0]}
		: {27'd0, f.inst[15:11]};
	d.operand.cc = f.inst[3:0];
	d.operand.adv_data = f.inst[10:5];
	d.pc = f.pc;
	d.branch_predict = f.branch_predict;
	d.branch_predict_addr = f.branch_predict_addr;
	d.pagefault = f.pagefault;
	d.privilege_error = f.privilege_error;
	d.invalid_inst = f.invalid_inst || !valid;
	d.paging_ena = f.paging_ena;
	d.kernel_access = f.kernel_access;
	return d;
endfunction

task automatic send_fetch(input pipe_pkg::fetch_bundle_t f);
	@(posedge iCLOCK);
	prev_valid <= 1'b1;
	prev_fetch <= f;
	// The bubble ahead of this word must not show as valid
	@(negedge iCLOCK);
	check_value("next_valid", 0, next_valid);
	@(posedge iCLOCK);
	prev_valid <= 1'b0;
endtask

task automatic check_decode(input pipe_pkg::decode_bundle_t exp);
	bit seen;
	int cycles;
	wait_valid(seen, cycles);
	if (seen && cycles != 1) begin
		error_count++;
		$display("Latency: next_valid rose %0d cycles after capture instead of one", cycles);
	end
	if (seen) begin
		check_value("pc", exp.pc, next_decode.pc);
		check_value("branch_predict", exp.branch_predict, next_decode.branch_predict);
		check_value("branch_predict_addr", exp.branch_predict_addr,
			next_decode.branch_predict_addr);
		check_value("pagefault", exp.pagefault, next_decode.pagefault);
		check_value("privilege_error", exp.privilege_error, next_decode.privilege_error);
		check_value("invalid_inst", exp.invalid_inst, next_decode.invalid_inst);
		check_value("paging_ena", exp.paging_ena, next_decode.paging_ena);
		check_value("kernel_access", exp.kernel_access, next_decode.kernel_access);
		check_value("cmd", exp.ctrl.cmd, next_decode.ctrl.cmd);
		check_value("ex_unit", exp.ctrl.ex_unit, next_decode.ctrl.ex_unit);
		// Low nine bits hold writeback through error
		check_value("ctrl_flags", exp.ctrl[8:0], next_decode.ctrl[8:0]);
		check_value("source0", exp.operand.source0, next_decode.operand.source0);
		check_value("destination", exp.operand.destination, next_decode.operand.destination);
		check_value("source1", exp.operand.source1, next_decode.operand.source1);
		check_value("cc", exp.operand.cc, next_decode.operand.cc);
		check_value("adv_data", exp.operand.adv_data, next_decode.operand.adv_data);
	end
endtask

task automatic test_reset_state();
	int errors_before;
	errors_before = error_count;
	@(negedge iCLOCK);
	check_value("next_valid", 0, next_valid);
	check_value("next_decode", 0, next_decode);
	check_value("prev_lock", 0, prev_lock);
	report_test("reset_state", errors_before);
endtask

task automatic test_decoding();
	logic [5:0] opcodes [18];
	pipe_pkg::fetch_bundle_t f;
	int errors_before;
	opcodes = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08,
		6'h09, 6'h10, 6'h12, 6'h15, 6'h18, 6'h19, 6'h20, 6'h28, 6'h29};
	errors_before = error_count;
	foreach (opcodes[i]) begin
		f = random_fetch(opcodes[i]);
		send_fetch(f);
		check_decode(expected_decode(f));
	end
	report_test("decoding", errors_before);
endtask

task automatic test_immediates();
	logic [5:0] opcodes [5];
	pipe_pkg::fetch_bundle_t f;
	int i;
	int errors_before;
	// ADDI, LD, ST, then two register forms
	opcodes = '{6'h10, 6'h18, 6'h19, 6'h00, 6'h07};
	errors_before = error_count;
	for (i = 0; i < 15; i++) begin
		f = random_fetch(opcodes[i % 5]);
		f.inst[15] = i[0];
		send_fetch(f);
		check_decode(expected_decode(f));
	end
	report_test("immediates", errors_before);
endtask

task automatic test_faults();
	logic [5:0] opcodes [3];
	pipe_pkg::fetch_bundle_t f;
	int errors_before;
	opcodes = '{6'h0a, 6'h11, 6'h3f};
	errors_before = error_count;
	foreach (opcodes[i]) begin
		f = random_fetch(opcodes[i]);
		send_fetch(f);
		check_decode(expected_decode(f));
	end
	// Fetch faults on a valid opcode pass through untouched
	f = random_fetch(6'h00);
	f.pagefault = 1'b1;
	send_fetch(f);
	check_decode(expected_decode(f));
	f = random_fetch(6'h03);
	f.privilege_error = 1'b1;
	send_fetch(f);
	check_decode(expected_decode(f));
	f = random_fetch(6'h18);
	f.invalid_inst = 1'b1;
	send_fetch(f);
	check_decode(expected_decode(f));
	report_test("faults", errors_before);
endtask

task automatic test_lock();
	pipe_pkg::fetch_bundle_t held;
	pipe_pkg::fetch_bundle_t pending;
	int hold_cycles;
	int i;
	int errors_before;
	errors_before = error_count;
	held = random_fetch(6'h01);
	pending = random_fetch(6'h12);
	hold_cycles = 2 + lcg_next() % 8;
	@(posedge iCLOCK);
	prev_valid <= 1'b1;
	prev_fetch <= held;
	@(posedge iCLOCK);
	// Next stage stalls while fetch already offers the following word
	prev_fetch <= pending;
	next_lock <= 1'b1;
	check_decode(expected_decode(held));
	for (i = 0; i < hold_cycles; i++) begin
		@(negedge iCLOCK);
		check_value("prev_lock", 1, prev_lock);
		check_value("next_valid", 1, next_valid);
		check_value("next_decode", expected_decode(held), next_decode);
	end
	@(posedge iCLOCK);
	next_lock <= 1'b0;
	@(posedge iCLOCK);
	prev_valid <= 1'b0;
	@(negedge iCLOCK);
	check_value("prev_lock", 0, prev_lock);
	check_value("next_valid", 1, next_valid);
	check_value("next_decode", expected_decode(pending), next_decode);
	report_test("lock", errors_before);
endtask

task automatic test_flush();
	pipe_pkg::fetch_bundle_t f;
	int pass;
	int errors_before;
	errors_before = error_count;
	for (pass = 0; pass < 2; pass++) begin
		f = random_fetch(6'h04);
		@(posedge iCLOCK);
		prev_valid <= 1'b1;
		prev_fetch <= f;
		@(posedge iCLOCK);
		next_lock <= 1'b1;
		check_decode(expected_decode(f));
		@(posedge iCLOCK);
		if (pass == 0) begin
			flush <= 1'b1;
		end else begin
			reset_sync <= 1'b1;
		end
		@(posedge iCLOCK);
		flush <= 1'b0;
		reset_sync <= 1'b0;
		@(negedge iCLOCK);
		check_value("next_valid", 0, next_valid);
		check_value("next_decode", 0, next_decode);
		@(posedge iCLOCK);
		prev_valid <= 1'b0;
		next_lock <= 1'b0;
	end
	report_test("flush", errors_before);
endtask

/* tb_decoder.sv */
// Testbench for the decode stage
// Drives fetch bundles into the stage, models the expected decode
// and checks the registered bundle under lock and flush
`timescale 1ns/1ps
`default_nettype none

module tb_decoder;

	localparam int WAIT_LIMIT = 20;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic flush;
	logic prev_valid;
	pipe_pkg::fetch_bundle_t prev_fetch;
	logic prev_lock;
	logic next_valid;
	pipe_pkg::decode_bundle_t next_decode;
	logic next_lock;

	logic [31:0] lcg_state;
	int check_count;
	int error_count;

	decode_stage i_dut (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.reset_sync (reset_sync),
		.flush (flush),
		.prev_valid (prev_valid),
		.prev_fetch (prev_fetch),
		.prev_lock (prev_lock),
		.next_valid (next_valid),
		.next_decode (next_decode),
		.next_lock (next_lock)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after capture
	task automatic wait_valid(output bit seen, output int cycles);
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			seen = (next_valid === 1'b1);
			cycles++;
		end
		if (!seen) begin
			error_count++;
			$display("Timeout: next_valid did not rise within %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
	endtask

	`include "tb_decoder_tests.svh"

	initial begin
		lcg_state = 32'h6cd5;
		check_count = 0;
		error_count = 0;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		flush = 1'b0;
		prev_valid = 1'b0;
		prev_fetch = '0;
		next_lock = 1'b0;
		repeat (16) @(posedge iCLOCK);
		inRESET <= 1'b1;
		test_reset_state();
		test_decoding();
		test_immediates();
		test_faults();
		test_lock();
		test_flush();
		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* decode_unit.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
decode_function.sv
operand_extract.sv
decode_stage.sv
tb_decoder.sv

/* Bender.yml */
package:
  name: decode_unit

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - decode_function.sv
      - operand_extract.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decoder.sv
